// File: rtl/riscv_isa_pkg.sv
// RISC-V ISA definitions
package riscv_isa_pkg;

    // Machine word width.
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;

    // Size code from the instruction's funct3 field.
    typedef logic [2:0] funct3_t;

    // Load size codes.
    localparam funct3_t f3_lb  = 3'b000;
    localparam funct3_t f3_lh  = 3'b001;
    localparam funct3_t f3_lw  = 3'b010;
    localparam funct3_t f3_lbu = 3'b100;
    localparam funct3_t f3_lhu = 3'b101;

    // Store size codes.
    localparam funct3_t f3_sb  = 3'b000;
    localparam funct3_t f3_sh  = 3'b001;
    localparam funct3_t f3_sw  = 3'b010;

endpackage

// File: rtl/mem_pipe_pkg.sv
// Pipeline stage bundles
package mem_pipe_pkg;

    import riscv_isa_pkg::*;

    // Execute to memory.
    typedef struct packed {
        word_t       pc;
        logic        mem_ren;
        logic        mem_wen;
        logic        r_wen;
        logic [3:0]  csr_wen;
        word_t       ex_result;
        word_t       csrs;
        logic [4:0]  rd;
        funct3_t     funct3;
        word_t       rs2_value;
        logic        jump_flag;
        logic        branch_flag;
    } ex_mem_t;

    // Memory to write-back.
    typedef struct packed {
        word_t       pc;
        logic        mem_ren;
        logic        r_wen;
        logic [3:0]  csr_wen;
        word_t       ex_result;
        word_t       csrs;
        logic [4:0]  rd;
        logic        jump_flag;
        logic        branch_flag;
        word_t       load_data;
    } mem_wb_t;

    // Register-file write port plus the carried CSR and control fields.
    typedef struct packed {
        logic        r_wen;
        logic [4:0]  rd;
        word_t       rd_wdata;
        logic [3:0]  csr_wen;
        word_t       csrs;
        word_t       pc;
        logic        jump_flag;
        logic        branch_flag;
    } wb_t;

endpackage

// File: rtl/data_mem.sv
// Byte-lane data memory
module data_mem #(
    parameter int mem_words = 256
) (
    input  logic                   clk,
    input  logic                   access,
    input  logic                   wen,
    input  riscv_isa_pkg::word_t   addr,
    input  riscv_isa_pkg::word_t   wdata,
    input  riscv_isa_pkg::funct3_t funct3,
    output riscv_isa_pkg::word_t   rdata
);

    import riscv_isa_pkg::*;

    localparam int idx_w = $clog2(mem_words);

    logic [3:0][7:0] mem [mem_words];

    logic [idx_w-1:0] idx;
    logic [1:0]       lane;
    logic [3:0]       byte_en;
    word_t            wlanes;
    word_t            rword;
    logic [7:0]       rbyte;
    logic [15:0]      rhalf;

    // Upper address bits are dropped, so accesses wrap.
    assign idx  = addr[idx_w+1:2];
    assign lane = addr[1:0];

    // Store data is replicated over the lanes and byte_en picks the target.
    always_comb begin
        byte_en = 4'b0000;
        wlanes  = wdata;
        case (funct3)
            f3_sb: begin
                byte_en = 4'b0001 << lane;
                wlanes  = {4{wdata[7:0]}};
            end
            f3_sh: begin
                byte_en = 4'b0011 << lane;
                wlanes  = {2{wdata[15:0]}};
            end
            f3_sw: begin
                byte_en = 4'b1111;
                wlanes  = wdata;
            end
            default: begin
                byte_en = 4'b0000;
                wlanes  = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (access && wen) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[idx][b] <= wlanes[8*b +: 8];
                end
            end
        end
    end

    // Combinational read of the addressed word.
    assign rword = mem[idx];
    assign rbyte = rword[8*lane +: 8];
    assign rhalf = rword[16*lane[1] +: 16];

    always_comb begin
        if (!access) begin
            rdata = '0;
        end else begin
            case (funct3)
                f3_lb: begin
                    rdata = {{24{rbyte[7]}}, rbyte};
                end
                f3_lh: begin
                    rdata = {{16{rhalf[15]}}, rhalf};
                end
                f3_lw: begin
                    rdata = rword;
                end
                f3_lbu: begin
                    rdata = {24'b0, rbyte};
                end
                f3_lhu: begin
                    rdata = {16'b0, rhalf};
                end
                default: begin
                    rdata = '0;
                end
            endcase
        end
    end

endmodule

// File: rtl/mem_stage.sv
// MEM pipeline stage
module mem_stage #(
    parameter int mem_words = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_pipe_pkg::ex_mem_t ex_in,
    output mem_pipe_pkg::mem_wb_t mem_out
);

    import riscv_isa_pkg::*;
    import mem_pipe_pkg::*;

    ex_mem_t ex_q;
    logic    mem_access;
    word_t   load_word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_q <= '0;
        end else begin
            ex_q <= ex_in;
        end
    end

    assign mem_access = ex_q.mem_ren | ex_q.mem_wen;

    // ex_result doubles as the memory address.
    data_mem #(
        .mem_words (mem_words)
    ) i_data_mem (
        .clk    (clk),
        .access (mem_access),
        .wen    (ex_q.mem_wen),
        .addr   (ex_q.ex_result),
        .wdata  (ex_q.rs2_value),
        .funct3 (ex_q.funct3),
        .rdata  (load_word)
    );

    always_comb begin
        mem_out.pc          = ex_q.pc;
        mem_out.mem_ren     = ex_q.mem_ren;
        mem_out.r_wen       = ex_q.r_wen;
        mem_out.csr_wen     = ex_q.csr_wen;
        mem_out.ex_result   = ex_q.ex_result;
        mem_out.csrs        = ex_q.csrs;
        mem_out.rd          = ex_q.rd;
        mem_out.jump_flag   = ex_q.jump_flag;
        mem_out.branch_flag = ex_q.branch_flag;
        mem_out.load_data   = load_word;
    end

endmodule

// File: rtl/wb_stage.sv
// Write-back stage
module wb_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_pipe_pkg::mem_wb_t mem_in,
    output mem_pipe_pkg::wb_t     wb_out
);

    import mem_pipe_pkg::*;

    wb_t wb_d;

    // Loads write the memory word, everything else the ALU result.
    always_comb begin
        wb_d.r_wen       = mem_in.r_wen;
        wb_d.rd          = mem_in.rd;
        wb_d.rd_wdata    = mem_in.mem_ren ? mem_in.load_data : mem_in.ex_result;
        wb_d.csr_wen     = mem_in.csr_wen;
        wb_d.csrs        = mem_in.csrs;
        wb_d.pc          = mem_in.pc;
        wb_d.jump_flag   = mem_in.jump_flag;
        wb_d.branch_flag = mem_in.branch_flag;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_out <= '0;
        end else begin
            wb_out <= wb_d;
        end
    end

endmodule

// File: rtl/mem_wb_top.sv
// Memory and write-back slice
module mem_wb_top #(
    parameter int mem_words = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_pipe_pkg::ex_mem_t ex_in,
    output mem_pipe_pkg::wb_t     wb_out
);

    import mem_pipe_pkg::*;

    mem_wb_t mem_wb;

    mem_stage #(
        .mem_words (mem_words)
    ) i_mem_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .ex_in   (ex_in),
        .mem_out (mem_wb)
    );

    wb_stage i_wb_stage (
        .clk    (clk),
        .rst_n  (rst_n),
        .mem_in (mem_wb),
        .wb_out (wb_out)
    );

endmodule

// File: test/mem_wb_model.svh
// Memory and pipeline reference model
`ifndef MEM_WB_MODEL_SVH
`define MEM_WB_MODEL_SVH

localparam int model_bytes = 4 * mem_words;
localparam int addr_w      = $clog2(model_bytes);

// Byte image of the data memory.
logic [7:0] model_mem [model_bytes];

// Expected write-back values, oldest first.
wb_t expect_q[$];

function automatic void apply_store(input word_t addr, input word_t data, input funct3_t f3);
    int base;
    int nbytes;
    base = int'(addr[addr_w-1:0]);
    case (f3)
        f3_sb:   nbytes = 1;
        f3_sh:   nbytes = 2;
        f3_sw:   nbytes = 4;
        default: nbytes = 0;
    endcase
    for (int i = 0; i < nbytes; i++) begin
        model_mem[base + i] = data[8*i +: 8];
    end
endfunction

// Aligned accesses keep every lane index inside the addressed word.
function automatic word_t load_result(input word_t addr, input funct3_t f3);
    int          base;
    logic [7:0]  b;
    logic [15:0] h;
    word_t       w;
    word_t       res;
    base = int'(addr[addr_w-1:0]);
    b    = model_mem[base];
    h    = {model_mem[base | 1], model_mem[base]};
    w    = {model_mem[base | 3], model_mem[base | 2], model_mem[base | 1], model_mem[base]};
    case (f3)
        f3_lb:   res = {{24{b[7]}}, b};
        f3_lh:   res = {{16{h[15]}}, h};
        f3_lw:   res = w;
        f3_lbu:  res = {24'h0, b};
        f3_lhu:  res = {16'h0, h};
        default: res = '0;
    endcase
    return res;
endfunction

function automatic wb_t expected_wb(input ex_mem_t b);
    wb_t e;
    e.r_wen       = b.r_wen;
    e.rd          = b.rd;
    e.rd_wdata    = b.mem_ren ? load_result(b.ex_result, b.funct3) : b.ex_result;
    e.csr_wen     = b.csr_wen;
    e.csrs        = b.csrs;
    e.pc          = b.pc;
    e.jump_flag   = b.jump_flag;
    e.branch_flag = b.branch_flag;
    return e;
endfunction

`endif

// File: test/mem_wb_tb.sv
// Memory and write-back testbench
module mem_wb_tb;

    import riscv_isa_pkg::*;
    import mem_pipe_pkg::*;

    localparam int mem_words     = 256;
    localparam int random_cycles = 400;

    logic        clk;
    logic        rst_n;
    ex_mem_t     ex_in;
    wb_t         wb_out;
    int          errors;
    int          test_start_errors;
    int          tests_passed;
    int          tests_failed;
    int          issued_total;
    int          checked_total;

    `include "mem_wb_model.svh"

    mem_wb_top #(
        .mem_words (mem_words)
    ) i_mem_wb_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_in  (ex_in),
        .wb_out (wb_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_field(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_wb(input wb_t exp);
        check_field("wb_out.r_wen", word_t'(exp.r_wen), word_t'(wb_out.r_wen));
        check_field("wb_out.rd", word_t'(exp.rd), word_t'(wb_out.rd));
        check_field("wb_out.rd_wdata", exp.rd_wdata, wb_out.rd_wdata);
        check_field("wb_out.csr_wen", word_t'(exp.csr_wen), word_t'(wb_out.csr_wen));
        check_field("wb_out.csrs", exp.csrs, wb_out.csrs);
        check_field("wb_out.pc", exp.pc, wb_out.pc);
        check_field("wb_out.jump_flag", word_t'(exp.jump_flag), word_t'(wb_out.jump_flag));
        check_field("wb_out.branch_flag", word_t'(exp.branch_flag), word_t'(wb_out.branch_flag));
    endtask

    task automatic check_reset_flags();
        check_field("wb_out.r_wen", '0, word_t'(wb_out.r_wen));
        check_field("wb_out.csr_wen", '0, word_t'(wb_out.csr_wen));
        check_field("wb_out.jump_flag", '0, word_t'(wb_out.jump_flag));
        check_field("wb_out.branch_flag", '0, word_t'(wb_out.branch_flag));
    endtask

    // The bundle issued two falling edges ago is on wb_out now.
    task automatic issue_bundle(input ex_mem_t b);
        if (expect_q.size() == 2) begin
            compare_wb(expect_q.pop_front());
            checked_total++;
        end
        expect_q.push_back(expected_wb(b));
        if (b.mem_wen) begin
            apply_store(b.ex_result, b.rs2_value, b.funct3);
        end
        ex_in = b;
        issued_total++;
    endtask

    task automatic drive_bundle(input ex_mem_t b);
        @(negedge clk);
        issue_bundle(b);
    endtask

    function automatic ex_mem_t bubble();
        ex_mem_t b;
        b    = '0;
        b.pc = 32'h0000_1000 + 4 * issued_total;
        return b;
    endfunction

    function automatic ex_mem_t mem_op(input logic load, input funct3_t f3, input word_t addr,
                                       input word_t data, input logic [4:0] rd);
        ex_mem_t b;
        b           = bubble();
        b.mem_ren   = load;
        b.mem_wen   = !load;
        b.r_wen     = load;
        b.ex_result = addr;
        b.rs2_value = data;
        b.funct3    = f3;
        b.rd        = rd;
        return b;
    endfunction

    // Legal size code, with the unsigned loads mixed in.
    function automatic funct3_t pick_size(input logic load, input logic [2:0] pick);
        funct3_t f3;
        f3 = (pick[1:0] == 2'b11) ? f3_lw : {1'b0, pick[1:0]};
        if (load && pick[2] && f3 != f3_lw) begin
            f3[2] = 1'b1;
        end
        return f3;
    endfunction

    // Kind 0 is a load, 1 a store, 2 an ALU result.
    function automatic ex_mem_t random_op(input int kind);
        ex_mem_t b;
        word_t   r;
        word_t   addr;
        r             = $urandom;
        addr          = $urandom;
        b.pc          = $urandom;
        b.csrs        = $urandom;
        b.rs2_value   = $urandom;
        b.ex_result   = $urandom;
        b.rd          = r[4:0];
        b.r_wen       = r[5];
        b.csr_wen     = r[9:6];
        b.jump_flag   = r[10];
        b.branch_flag = r[11];
        b.funct3      = r[14:12];
        b.mem_ren     = (kind == 0);
        b.mem_wen     = (kind == 1);
        if (kind != 2) begin
            b.funct3 = pick_size(b.mem_ren, r[14:12]);
            addr     = addr & word_t'(model_bytes - 1);
            if (b.funct3[1:0] == 2'b01) begin
                addr[0] = 1'b0;
            end else if (b.funct3[1:0] == 2'b10) begin
                addr[1:0] = 2'b00;
            end
            b.ex_result = addr;
        end
        return b;
    endfunction

    task automatic drain_pipeline();
        int target;
        int guard;
        target = issued_total;
        guard  = 0;
        while (checked_total < target && guard < 4) begin
            drive_bundle(bubble());
            guard++;
        end
        if (checked_total < target) begin
            $display("Pipeline did not drain within %0d cycles", guard);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        drain_pipeline();
        if (errors == test_start_errors) begin
            $display("Test %s: passed", name);
            tests_passed++;
        end else begin
            $display("Test %s: failed with %0d errors", name, errors - test_start_errors);
            tests_failed++;
        end
        test_start_errors = errors;
    endtask

    initial begin
        word_t fill;
        errors            = 0;
        test_start_errors = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        issued_total      = 0;
        checked_total     = 0;
        void'($urandom(39305));
        rst_n             = 1'b0;
        ex_in             = '1;

        // Reset clears the stages even with a busy bundle on the input.
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_reset_flags();
        end
        rst_n = 1'b1;
        issue_bundle(bubble());
        @(negedge clk);
        check_reset_flags();
        issue_bundle(bubble());
        end_test("reset");

        drive_bundle(mem_op(1'b0, f3_sw, 32'h40, 32'hdead_beef, 5'd0));
        drive_bundle(bubble());
        drive_bundle(mem_op(1'b1, f3_lw, 32'h40, 32'h0, 5'd7));
        end_test("word store and load");

        drive_bundle(mem_op(1'b0, f3_sw, 32'h80, 32'h1122_3344, 5'd0));
        drive_bundle(mem_op(1'b0, f3_sb, 32'h81, 32'h0000_00a5, 5'd0));
        drive_bundle(mem_op(1'b0, f3_sh, 32'h82, 32'h0000_8001, 5'd0));
        drive_bundle(mem_op(1'b1, f3_lb, 32'h81, 32'h0, 5'd1));
        drive_bundle(mem_op(1'b1, f3_lbu, 32'h81, 32'h0, 5'd2));
        drive_bundle(mem_op(1'b1, f3_lh, 32'h82, 32'h0, 5'd3));
        drive_bundle(mem_op(1'b1, f3_lhu, 32'h82, 32'h0, 5'd4));
        drive_bundle(mem_op(1'b1, f3_lw, 32'h80, 32'h0, 5'd5));
        drive_bundle(mem_op(1'b1, f3_lb, 32'h80, 32'h0, 5'd6));
        end_test("sized accesses");

        drive_bundle(mem_op(1'b0, f3_sw, 32'hc0, 32'h1234_5678, 5'd0));
        drive_bundle(mem_op(1'b1, f3_lw, 32'hc0, 32'h0, 5'd8));
        drive_bundle(mem_op(1'b0, f3_sb, 32'hc3, 32'h0000_009a, 5'd0));
        drive_bundle(mem_op(1'b1, f3_lb, 32'hc3, 32'h0, 5'd9));
        end_test("store then load");

        for (int n = 0; n < 8; n++) begin
            drive_bundle(random_op(2));
        end
        end_test("pass-through");

        // Fill every word first so that random loads never see unwritten bytes.
        for (int w = 0; w < mem_words; w++) begin
            fill = (w * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
            drive_bundle(mem_op(1'b0, f3_sw, word_t'(4 * w), fill, 5'd0));
        end
        for (int n = 0; n < random_cycles; n++) begin
            drive_bundle(random_op(int'($urandom % 3)));
        end
        end_test("random mix");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: mem_wb.f
+incdir+test
rtl/riscv_isa_pkg.sv
rtl/mem_pipe_pkg.sv
rtl/data_mem.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/mem_wb_top.sv
test/mem_wb_tb.sv
